// ==== design/cacc_fp_defines.svh ====
// fp accumulation cell widths
`ifndef CACC_FP_DEFINES_SVH
`define CACC_FP_DEFINES_SVH

// ==========================================================================
// input data word, unnormalized, bias 30
// ==========================================================================
`define CACC_DI_WIDTH      44
`define CACC_DI_EXP_W      6
`define CACC_DI_MANT_W     38
`define CACC_DI_NORM_W     36
`define CACC_DI_EXP_ADJ    47

// ==========================================================================
// partial sum word, normalized, bias 63
// ==========================================================================
`define CACC_OI_WIDTH      48
`define CACC_OI_EXP_W      8
`define CACC_OI_MANT_W     40
`define CACC_CUT_W         3
`define CACC_SUM_W         41
`define CACC_TRANS_W       42
`define CACC_NAN_KEEP_DI   11
`define CACC_NAN_KEEP_OI   11

// fp32 output
`define CACC_FP32_MANT_W   23
`define CACC_FP32_EXP_ADJ  64
`define CACC_FP32_CUT_W    15

`endif

// ==== design/cacc_fp_pkg.sv ====
// fp accumulation cell types
`include "cacc_fp_defines.svh"

package cacc_fp_pkg;

  // output routing, partial sum or fp32
  typedef enum logic {
    SEL_PARTIAL = 1'b0,
    SEL_FINAL   = 1'b1
  } cacc_out_sel_e;

  // data word from the mac array
  typedef struct packed {
    logic [`CACC_DI_EXP_W-1:0]  expo;
    logic [`CACC_DI_MANT_W-1:0] mant;
  } cacc_di_t;

  // partial sum word, in and out
  typedef struct packed {
    logic [`CACC_OI_EXP_W-1:0]  expo;
    logic [`CACC_OI_MANT_W-1:0] mant;
  } cacc_oi_t;

  // stage 1 register
  typedef struct packed {
    logic [`CACC_OI_MANT_W-1:0] di_mant;
    logic [`CACC_OI_MANT_W-1:0] oi_mant;
    logic [`CACC_CUT_W-1:0]     cut;
    logic [`CACC_OI_EXP_W-1:0]  expo;
    logic                       nan;
    cacc_out_sel_e              sel;
  } cacc_align_t;

  // stage 2 register, mantissa with guard and sticky at the bottom
  typedef struct packed {
    logic [`CACC_TRANS_W-1:0]   mant;
    logic [`CACC_OI_EXP_W-1:0]  expo;
    logic                       nan;
    cacc_out_sel_e              sel;
  } cacc_nrml_t;

  // ieee single
  typedef struct packed {
    logic                         sign;
    logic [7:0]                   expo;
    logic [`CACC_FP32_MANT_W-1:0] mant;
  } cacc_fp32_t;

endpackage

// ==== design/cacc_lead_sign_cnt.sv ====
// leading sign bit counter
`timescale 1ns/1ns

module cacc_lead_sign_cnt #(
  parameter int WIDTH = 36
) (
  input  logic [WIDTH-1:0] vec,
  output logic [5:0]       cnt
);

  // set once the first bit differing from the sign is seen
  logic done;

  // walk down from just below the sign bit
  // count stops at the first bit that differs
  // an all-sign vector gives WIDTH-1
  always_comb begin
    cnt  = 6'd0;
    done = 1'b0;
    for (int i = WIDTH - 2; i >= 0; i--) begin
      if (!done && (vec[i] == vec[WIDTH-1])) begin
        cnt = cnt + 6'd1;
      end else begin
        done = 1'b1;
      end
    end
  end

endmodule

// ==== design/cacc_fp_align.sv ====
// exponent align stage
`timescale 1ns/1ns
`include "cacc_fp_defines.svh"

module cacc_fp_align (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  cacc_fp_pkg::cacc_di_t      in_data,
  input  cacc_fp_pkg::cacc_oi_t      in_op,
  input  logic                       in_op_valid,
  input  cacc_fp_pkg::cacc_out_sel_e in_sel,
  input  logic                       in_valid,
  output cacc_fp_pkg::cacc_align_t   align_word,
  output logic                       align_vld
);

  cacc_fp_pkg::cacc_oi_t    op_mask;
  cacc_fp_pkg::cacc_align_t align_nxt;
  logic                         di_sign, oi_sign;
  logic                         di_zero, oi_zero;
  logic                         di_nan, oi_nan, in_nan;
  logic [5:0]                   di_lead;
  logic [6:0]                   di_expm;
  logic [`CACC_DI_NORM_W-1:0]   di_manm, di_mans;
  logic [`CACC_OI_MANT_W-1:0]   oi_mans;
  logic [`CACC_OI_EXP_W-1:0]    di_expo, oi_expo, max_expo;
  logic [`CACC_OI_EXP_W-1:0]    di_shift, oi_shift;
  logic [`CACC_OI_MANT_W+`CACC_CUT_W-1:0] di_algn, oi_algn;

  // arithmetic shift right through an 80 bit window
  // lower half gives guard, round and sticky
  function automatic logic [`CACC_OI_MANT_W+`CACC_CUT_W-1:0] align_shift(
    input logic [`CACC_OI_MANT_W-1:0] mant,
    input logic [`CACC_OI_EXP_W-1:0]  shift,
    input logic                       sign
  );
    logic [2*`CACC_OI_MANT_W-1:0] wide;
    logic [`CACC_OI_MANT_W-1:0]   kept;
    wide = $signed({mant, {`CACC_OI_MANT_W{1'b0}}}) >>> shift;
    // everything shifted out, only sign left
    kept = (shift >= `CACC_OI_MANT_W) ? {`CACC_OI_MANT_W{sign}} : wide[79:40];
    return {kept, wide[39:38], |wide[37:0]};
  endfunction

  // ==========================================================================
  // unpack and classify
  // ==========================================================================
  // operand counts as zero when not valid
  assign op_mask = in_op_valid ? in_op : '0;

  assign di_sign = in_data.mant[`CACC_DI_MANT_W-1];
  assign oi_sign = op_mask.mant[`CACC_OI_MANT_W-1];
  assign di_zero = ~(|in_data.mant);
  assign oi_zero = ~(|op_mask.mant);
  assign di_nan  = &in_data.expo;
  assign oi_nan  = &op_mask.expo;
  assign in_nan  = di_nan | oi_nan;

  // top two data bits repeat the sign, count on the low 36
  cacc_lead_sign_cnt #(
    .WIDTH (`CACC_DI_NORM_W)
  ) u_di_lsc (
    .vec (in_data.mant[`CACC_DI_NORM_W-1:0]),
    .cnt (di_lead)
  );

  // normalize data mantissa, move exponent to bias 63
  assign di_expm = {1'b0, in_data.expo} + 7'(`CACC_DI_EXP_ADJ) - {1'b0, di_lead};
  assign di_manm = $signed(in_data.mant[`CACC_DI_NORM_W-1:0]) <<< di_lead;

  // nan keeps only the payload of the nan word
  assign di_mans = oi_nan ? '0 :
                   di_nan ? {in_data.mant[`CACC_DI_MANT_W-1 -: `CACC_NAN_KEEP_DI],
                             {(`CACC_DI_NORM_W-`CACC_NAN_KEEP_DI){1'b0}}} :
                   di_manm;
  assign oi_mans = oi_nan ? {op_mask.mant[`CACC_OI_MANT_W-1 -: `CACC_NAN_KEEP_OI],
                             {(`CACC_OI_MANT_W-`CACC_NAN_KEEP_OI){1'b0}}} :
                   di_nan ? '0 :
                   op_mask.mant;

  assign di_expo = in_nan ? '1 : di_zero ? '0 : {1'b0, di_expm};
  assign oi_expo = in_nan ? '1 : oi_zero ? '0 : op_mask.expo;

  // ==========================================================================
  // align to the larger exponent
  // ==========================================================================
  assign max_expo = (di_expo > oi_expo) ? di_expo : oi_expo;
  assign di_shift = max_expo - di_expo;
  assign oi_shift = max_expo - oi_expo;

  assign di_algn = align_shift({di_mans, 4'b0}, di_shift, di_sign);
  assign oi_algn = align_shift(oi_mans, oi_shift, oi_sign);

  always_comb begin
    align_nxt.di_mant = di_algn[`CACC_OI_MANT_W+`CACC_CUT_W-1:`CACC_CUT_W];
    align_nxt.oi_mant = oi_algn[`CACC_OI_MANT_W+`CACC_CUT_W-1:`CACC_CUT_W];
    // cut bits come from the smaller one only
    align_nxt.cut     = (di_expo > oi_expo) ? oi_algn[`CACC_CUT_W-1:0] :
                        (di_expo < oi_expo) ? di_algn[`CACC_CUT_W-1:0] : '0;
    align_nxt.expo    = max_expo;
    align_nxt.nan     = in_nan;
    align_nxt.sel     = in_sel;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid) begin
      align_word <= align_nxt;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      align_vld <= 1'b0;
    end else begin
      align_vld <= in_valid;
    end
  end

endmodule

// ==== design/cacc_fp_sum_nrml.sv ====
// mantissa add and normalize stage
`timescale 1ns/1ns
`include "cacc_fp_defines.svh"

module cacc_fp_sum_nrml (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  cacc_fp_pkg::cacc_align_t align_word,
  input  logic                     align_vld,
  output cacc_fp_pkg::cacc_nrml_t  nrml_word,
  output logic                     nrml_vld
);

  cacc_fp_pkg::cacc_nrml_t nrml_nxt;
  logic [`CACC_SUM_W-1:0]            mant_sum;
  logic [`CACC_SUM_W+`CACC_CUT_W-1:0] sum_total;
  logic [`CACC_SUM_W+`CACC_CUT_W:0]   sum_comp, sum_scmp;
  logic [5:0]                        lead;
  logic [`CACC_OI_EXP_W-1:0]         expo_nrml;

  // ==========================================================================
  // signed add, one bit of growth
  // ==========================================================================
  assign mant_sum  = $signed(align_word.di_mant) + $signed(align_word.oi_mant);
  assign sum_total = {mant_sum, align_word.cut};

  cacc_lead_sign_cnt #(
    .WIDTH (`CACC_SUM_W + `CACC_CUT_W)
  ) u_sum_lsc (
    .vec (sum_total),
    .cnt (lead)
  );

  // sum carries one integer bit more than the aligned words
  assign expo_nrml = align_word.expo + 8'd1 - {2'b0, lead};

  // ==========================================================================
  // normalize shift
  // ==========================================================================
  // spare low bit so that no lead means a right shift by one
  assign sum_comp = {sum_total, 1'b0};
  assign sum_scmp = (|lead) ? $signed(sum_comp) <<< (lead - 6'd1) :
                              $signed(sum_comp) >>> 1;

  always_comb begin
    // nan goes through raw, payload stays where it was
    if (align_word.nan) begin
      nrml_nxt.mant = {mant_sum[`CACC_OI_MANT_W-1:0], 2'b0};
    end else begin
      // 40 bit mantissa, guard, then everything below as sticky
      nrml_nxt.mant = {sum_scmp[43:3], |sum_scmp[2:0]};
    end
    nrml_nxt.expo = expo_nrml;
    nrml_nxt.nan  = align_word.nan;
    nrml_nxt.sel  = align_word.sel;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (align_vld) begin
      nrml_word <= nrml_nxt;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nrml_vld <= 1'b0;
    end else begin
      nrml_vld <= align_vld;
    end
  end

endmodule

// ==== design/cacc_fp_round.sv ====
// round and partial sum output stage
`timescale 1ns/1ns
`include "cacc_fp_defines.svh"

module cacc_fp_round (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  cacc_fp_pkg::cacc_nrml_t nrml_word,
  input  logic                    nrml_vld,
  output cacc_fp_pkg::cacc_oi_t   out_partial_data,
  output logic                    out_partial_valid,
  output logic                    final_vld,
  output logic                    final_sel
);

  cacc_fp_pkg::cacc_oi_t partial_nxt;
  logic                       sum_sign, sum_guard, sum_stick;
  logic [`CACC_OI_MANT_W-1:0] sum_effect;
  logic                       point5, carry_pos, carry_neg;
  logic [`CACC_OI_MANT_W:0]   mant_round, round_shr, mant_nmlz;
  logic                       mant_zero;
  logic [`CACC_OI_EXP_W-1:0]  expo_nmlz;

  assign sum_sign   = nrml_word.mant[`CACC_TRANS_W-1];
  assign sum_effect = nrml_word.mant[`CACC_TRANS_W-1:2];
  assign sum_guard  = nrml_word.mant[1];
  assign sum_stick  = nrml_word.mant[0];

  // half up when positive and sticky needed when negative
  assign point5     = sum_guard & (~sum_sign | sum_stick);
  assign mant_round = $signed(sum_effect) + $signed({1'b0, point5});

  // 01.111..1 rounds up into the sign bit
  assign carry_pos = ~sum_sign & (&sum_effect[38:0]) & point5;
  // 10.111..1 rounds to 11.000 and loses one bit of magnitude
  assign carry_neg = sum_sign & ~sum_effect[38] & (&sum_effect[37:0]) & point5;

  assign round_shr = $signed(mant_round) >>> carry_pos;
  assign mant_nmlz = carry_neg ? {mant_round[39:0], 1'b0} : round_shr;
  assign mant_zero = ~(|mant_nmlz[`CACC_OI_MANT_W-1:0]);

  assign expo_nmlz = carry_neg ? nrml_word.expo - 8'd1 :
                                 nrml_word.expo + {7'd0, carry_pos};

  always_comb begin
    partial_nxt.mant = mant_nmlz[`CACC_OI_MANT_W-1:0];
    partial_nxt.expo = nrml_word.nan ? '1 : mant_zero ? '0 : expo_nmlz;
  end

  // updates for every item including final ones
  always_ff @(posedge nvdla_core_clk) begin
    if (nrml_vld) begin
      out_partial_data <= partial_nxt;
    end
  end

  // partial strobe here and final routing handed down
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_partial_valid <= 1'b0;
      final_vld         <= 1'b0;
      final_sel         <= 1'b0;
    end else begin
      out_partial_valid <= nrml_vld & (nrml_word.sel == cacc_fp_pkg::SEL_PARTIAL);
      final_vld         <= nrml_vld;
      final_sel         <= (nrml_word.sel == cacc_fp_pkg::SEL_FINAL);
    end
  end

endmodule

// ==== design/cacc_fp32_conv.sv ====
// partial sum to fp32 stage
`timescale 1ns/1ns
`include "cacc_fp_defines.svh"

module cacc_fp32_conv (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  cacc_fp_pkg::cacc_oi_t  partial,
  input  logic                   final_vld,
  input  logic                   final_sel,
  output cacc_fp_pkg::cacc_fp32_t out_final_data,
  output logic                   out_final_valid
);

  cacc_fp_pkg::cacc_fp32_t fp32_nxt;
  logic                          p_sign, p_neg2, p_nan, p_zero;
  logic [`CACC_OI_MANT_W-2:0]    p_umant, mant_abs;
  logic [`CACC_FP32_CUT_W-1:0]   mant_cut;
  logic [`CACC_FP32_MANT_W:0]    mant_effect;
  logic                          point5, mant_carry;
  logic [`CACC_FP32_MANT_W+1:0]  mant_round;
  logic [`CACC_OI_EXP_W-1:0]     expo_round;

  // ==========================================================================
  // classify the partial sum
  // ==========================================================================
  assign p_sign  = partial.mant[`CACC_OI_MANT_W-1];
  assign p_umant = partial.mant[`CACC_OI_MANT_W-2:0];
  // exactly -2 has a magnitude one power of two above the exponent
  assign p_neg2  = p_sign & ~(|p_umant);
  assign p_nan   = &partial.expo;
  assign p_zero  = ~(|partial.mant);

  // ==========================================================================
  // magnitude rounded at bit 14
  // ==========================================================================
  assign mant_abs    = p_sign ? (~p_umant + 39'd1) : p_umant;
  assign mant_cut    = mant_abs[`CACC_FP32_CUT_W-1:0];
  assign mant_effect = mant_abs[`CACC_OI_MANT_W-2:`CACC_FP32_CUT_W];

  assign point5     = mant_cut[`CACC_FP32_CUT_W-1];
  assign mant_carry = (&mant_effect) & point5;
  assign mant_round = mant_effect + {24'd0, point5};

  // rebias 63 to 127
  assign expo_round = partial.expo + 8'(`CACC_FP32_EXP_ADJ) + {7'd0, mant_carry | p_neg2};

  always_comb begin
    fp32_nxt.sign = p_sign;
    fp32_nxt.expo = p_zero ? '0 : p_nan ? '1 : expo_round;
    // nan keeps the top 10 payload bits
    if (p_nan) begin
      fp32_nxt.mant = {13'd0, p_umant[38:29]};
    end else begin
      // hidden one and rounding carry drop off the top
      fp32_nxt.mant = mant_round[`CACC_FP32_MANT_W-1:0];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (final_vld & final_sel) begin
      out_final_data <= fp32_nxt;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_final_valid <= 1'b0;
    end else begin
      out_final_valid <= final_vld & final_sel;
    end
  end

endmodule

// ==== design/cacc_fp_calc.sv ====
// fp accumulation cell top
`timescale 1ns/1ns

module cacc_fp_calc (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  cacc_fp_pkg::cacc_di_t      in_data,
  input  cacc_fp_pkg::cacc_oi_t      in_op,
  input  logic                       in_op_valid,
  input  cacc_fp_pkg::cacc_out_sel_e in_sel,
  input  logic                       in_valid,
  output cacc_fp_pkg::cacc_oi_t      out_partial_data,
  output logic                       out_partial_valid,
  output cacc_fp_pkg::cacc_fp32_t    out_final_data,
  output logic                       out_final_valid
);

  cacc_fp_pkg::cacc_align_t align_word;
  cacc_fp_pkg::cacc_nrml_t  nrml_word;
  logic                     align_vld;
  logic                     nrml_vld;
  logic                     final_vld;
  logic                     final_sel;

  // ==========================================================================
  // four stage chain
  // ==========================================================================
  cacc_fp_align u_align (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_data         (in_data),
    .in_op           (in_op),
    .in_op_valid     (in_op_valid),
    .in_sel          (in_sel),
    .in_valid        (in_valid),
    .align_word      (align_word),
    .align_vld       (align_vld)
  );

  cacc_fp_sum_nrml u_sum_nrml (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .align_word      (align_word),
    .align_vld       (align_vld),
    .nrml_word       (nrml_word),
    .nrml_vld        (nrml_vld)
  );

  cacc_fp_round u_round (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .nrml_word         (nrml_word),
    .nrml_vld          (nrml_vld),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid),
    .final_vld         (final_vld),
    .final_sel         (final_sel)
  );

  // final items take the registered partial word
  cacc_fp32_conv u_fp32_conv (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .partial         (out_partial_data),
    .final_vld       (final_vld),
    .final_sel       (final_sel),
    .out_final_data  (out_final_data),
    .out_final_valid (out_final_valid)
  );

endmodule

// ==== tb/cacc_fp_ref_model.svh ====
// fp accumulation reference model
`ifndef CACC_FP_REF_MODEL_SVH
`define CACC_FP_REF_MODEL_SVH
`include "cacc_fp_defines.svh"

// bits below the msb of a w bit value that repeat it
function automatic int sign_run(logic [63:0] v, int w);
  int n;
  n = 0;
  for (int i = w - 2; i >= 0 && v[i] == v[w-1]; i--) begin
    n++;
  end
  return n;
endfunction

// move a 40 bit mantissa down to a larger exponent
// result is kept bits, guard, round, sticky
function automatic logic [42:0] align_to(logic [39:0] m, int sh);
  logic signed [79:0] w;
  logic [39:0]        keep;
  w    = {m, 40'd0};
  w    = w >>> sh;
  keep = (sh >= `CACC_OI_MANT_W) ? {40{m[39]}} : w[79:40];
  return {keep, w[39:38], |w[37:0]};
endfunction

// expected partial sum word for one item
function automatic cacc_fp_pkg::cacc_oi_t model_partial(cacc_fp_pkg::cacc_di_t d,
                                                       cacc_fp_pkg::cacc_oi_t op,
                                                       logic op_vld);
  cacc_fp_pkg::cacc_oi_t o;
  cacc_fp_pkg::cacc_oi_t r;
  logic                  nan_d, nan_o, nan, up;
  int                    n, de, oe, me;
  logic [39:0]           dm, om;
  logic [42:0]           da, oa;
  logic [2:0]            cut;
  logic signed [40:0]    sum, rnd;
  logic signed [43:0]    tot;
  logic signed [44:0]    sh;
  logic [41:0]           nm;
  logic [7:0]            e;
  o     = op_vld ? op : '0;
  nan_d = &d.expo;
  nan_o = &o.expo;
  nan   = nan_d | nan_o;
  // data value normalized into the 40 bit partial format
  n  = sign_run(64'(d.mant[35:0]), `CACC_DI_NORM_W);
  dm = {d.mant[35:0] << n, 4'd0};
  om = o.mant;
  if (nan_o) begin
    dm = '0;
    om = {o.mant[39:29], 29'd0};
  end else if (nan_d) begin
    dm = {d.mant[37:27], 29'd0};
    om = '0;
  end
  de = (d.mant == 0) ? 0 : d.expo + `CACC_DI_EXP_ADJ - n;
  oe = (o.mant == 0) ? 0 : o.expo;
  if (nan) begin
    de = 255;
    oe = 255;
  end
  me  = (de > oe) ? de : oe;
  da  = align_to(dm, me - de);
  oa  = align_to(om, me - oe);
  cut = (de > oe) ? oa[2:0] : (oe > de) ? da[2:0] : 3'd0;
  sum = $signed(da[42:3]) + $signed(oa[42:3]);
  // renormalize the sum, carry bit counted in the exponent
  tot = {sum, cut};
  n   = sign_run(64'(tot), 44);
  e   = 8'(me + 1 - n);
  sh  = tot;
  sh  = sh <<< n;
  nm  = nan ? {sum[39:0], 2'd0} : {sh[43:3], |sh[2:0]};
  // nearest, ties up for positive, negative ties go down
  up  = nm[1] & (~nm[41] | nm[0]);
  rnd = $signed(nm[41:2]) + $signed({1'b0, up});
  r.expo = e;
  r.mant = rnd[39:0];
  if (!nm[41] && rnd[39]) begin
    r.mant = rnd[40:1];
    r.expo = e + 8'd1;
  end else if (nm[41] && !nm[40] && rnd[38]) begin
    r.mant = {rnd[38:0], 1'b0};
    r.expo = e - 8'd1;
  end
  if (nan) begin
    r.expo = 8'hff;
  end else if (r.mant == 0) begin
    r.expo = 8'h00;
  end
  return r;
endfunction

// expected fp32 word from a partial sum
function automatic cacc_fp_pkg::cacc_fp32_t model_fp32(cacc_fp_pkg::cacc_oi_t p);
  cacc_fp_pkg::cacc_fp32_t f;
  logic [39:0]             mag;
  logic [24:0]             k;
  mag    = p.mant[39] ? (~p.mant + 40'd1) : p.mant;
  k      = {1'b0, mag[38:15]} + {24'd0, mag[14]};
  f.sign = p.mant[39];
  // mag bit 39 only for exactly minus two
  f.expo = p.expo + 8'(`CACC_FP32_EXP_ADJ) + {7'd0, k[24] | mag[39]};
  f.mant = k[22:0];
  if (p.mant == 0) begin
    f.expo = 8'h00;
  end else if (&p.expo) begin
    f.expo = 8'hff;
    f.mant = {13'd0, p.mant[38:29]};
  end
  return f;
endfunction

`endif

// ==== tb/tb_cacc_fp_calc.sv ====
// fp accumulation cell testbench
`timescale 1ns/1ns
`include "cacc_fp_defines.svh"

module tb_cacc_fp_calc;

  `include "cacc_fp_ref_model.svh"

  localparam int N_ITEMS = 40;
  localparam int N_TESTS = 6;
  // all items, streaming gaps of up to 3, drain per test, reset and margin
  localparam int MAX_CYC = N_TESTS * N_ITEMS + 3 * N_ITEMS + N_TESTS * 8 + 20;

  logic                       nvdla_core_clk, nvdla_core_rstn;
  cacc_fp_pkg::cacc_di_t      in_data;
  cacc_fp_pkg::cacc_oi_t      in_op;
  logic                       in_op_valid, in_valid;
  cacc_fp_pkg::cacc_out_sel_e in_sel;
  cacc_fp_pkg::cacc_oi_t      out_partial_data;
  cacc_fp_pkg::cacc_fp32_t    out_final_data;
  logic                       out_partial_valid, out_final_valid;

  // expected results and the cycle each item was driven in
  cacc_fp_pkg::cacc_oi_t   part_q[$];
  cacc_fp_pkg::cacc_fp32_t fin_q[$];
  int                      part_t[$];
  int                      fin_t[$];
  int                      cyc = 0;
  int                      errors, checks;
  string                   test_name;

  cacc_fp_calc dut (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .in_data           (in_data),
    .in_op             (in_op),
    .in_op_valid       (in_op_valid),
    .in_sel            (in_sel),
    .in_valid          (in_valid),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid),
    .out_final_data    (out_final_data),
    .out_final_valid   (out_final_valid)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_partial(cacc_fp_pkg::cacc_oi_t exp_w, cacc_fp_pkg::cacc_oi_t act_w);
    checks++;
    if (act_w !== exp_w) begin
      errors++;
      $display("CHECK FAILED %s partial expected %h actual %h", test_name, exp_w, act_w);
    end
  endtask

  task automatic check_final(cacc_fp_pkg::cacc_fp32_t exp_w, cacc_fp_pkg::cacc_fp32_t act_w);
    checks++;
    if (act_w !== exp_w) begin
      errors++;
      $display("CHECK FAILED %s final expected %h actual %h", test_name, exp_w, act_w);
    end
  endtask

  task automatic check_latency(string kind, int got, int want);
    if (got != want) begin
      errors++;
      $display("test %s: %s result came %0d cycles after its input instead of %0d",
               test_name, kind, got, want);
    end
  endtask

  // watchdog counter that also stamps latency
  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
    if (cyc > MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn && out_partial_valid) begin
      if (part_q.size() == 0) begin
        errors++;
        $display("test %s: partial strobe with no partial result expected", test_name);
      end else begin
        check_partial(part_q.pop_front(), out_partial_data);
        check_latency("partial", cyc - part_t.pop_front(), 3);
      end
    end
    if (nvdla_core_rstn && out_final_valid) begin
      if (fin_q.size() == 0) begin
        errors++;
        $display("test %s: final strobe with no final result expected", test_name);
      end else begin
        check_final(fin_q.pop_front(), out_final_data);
        check_latency("final", cyc - fin_t.pop_front(), 4);
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  // top three mantissa bits equal and exponent never nan
  function automatic cacc_fp_pkg::cacc_di_t rand_data();
    cacc_fp_pkg::cacc_di_t d;
    d.expo       = 6'($urandom_range(62, 0));
    d.mant[35:0] = 36'({$urandom, $urandom});
    // some small magnitudes for long normalize shifts
    if ($urandom_range(3, 0) == 0) begin
      d.mant[35:0] = $signed(d.mant[35:0]) >>> $urandom_range(34, 1);
    end
    d.mant[37:36] = {2{d.mant[35]}};
    return d;
  endfunction

  // normalized operand with bit 39 differing from bit 38
  function automatic cacc_fp_pkg::cacc_oi_t rand_op();
    cacc_fp_pkg::cacc_oi_t o;
    o.expo     = 8'($urandom_range(100, 40));
    o.mant     = 40'({$urandom, $urandom});
    o.mant[38] = ~o.mant[39];
    return o;
  endfunction

  task automatic send(cacc_fp_pkg::cacc_di_t d, cacc_fp_pkg::cacc_oi_t o, logic ov,
                      cacc_fp_pkg::cacc_out_sel_e sel);
    cacc_fp_pkg::cacc_oi_t p;
    @(negedge nvdla_core_clk);
    in_data     = d;
    in_op       = o;
    in_op_valid = ov;
    in_sel      = sel;
    in_valid    = 1'b1;
    p = model_partial(d, o, ov);
    if (sel == cacc_fp_pkg::SEL_PARTIAL) begin
      part_q.push_back(p);
      part_t.push_back(cyc);
    end else begin
      fin_q.push_back(model_fp32(p));
      fin_t.push_back(cyc);
    end
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge nvdla_core_clk);
      in_valid = 1'b0;
    end
  endtask

  // kind 0 partial, 1 final, 2 masking, 3 nan, 4 zero, 5 streaming
  task automatic run_test(string name, int kind);
    int                         err0;
    logic                       ov;
    cacc_fp_pkg::cacc_di_t      d;
    cacc_fp_pkg::cacc_oi_t      o;
    cacc_fp_pkg::cacc_oi_t      p;
    cacc_fp_pkg::cacc_out_sel_e sel;
    test_name = name;
    err0      = errors;
    for (int i = 0; i < N_ITEMS; i++) begin
      d   = rand_data();
      o   = rand_op();
      ov  = 1'b1;
      sel = (kind == 1) ? cacc_fp_pkg::SEL_FINAL : cacc_fp_pkg::SEL_PARTIAL;
      if (kind == 3 || kind == 4) begin
        sel = i[1] ? cacc_fp_pkg::SEL_FINAL : cacc_fp_pkg::SEL_PARTIAL;
      end
      case (kind)
        2: ov = 1'b0;
        3: begin
          if (i[0]) begin
            d.expo = '1;
          end else begin
            o.expo = '1;
          end
        end
        4: begin
          if (i[0]) begin
            d.mant = '0;
            ov     = 1'b0;
          end else begin
            // keep the data off a power of two so its negation stays normalized
            d.mant[0] = 1'b1;
            d.mant[1] = ~d.mant[35];
            p      = model_partial(d, o, 1'b0);
            o.expo = p.expo;
            o.mant = -p.mant;
          end
        end
        5: sel = cacc_fp_pkg::cacc_out_sel_e'(1'($urandom_range(1, 0)));
        default: ;
      endcase
      send(d, o, ov, sel);
      if (kind == 5) begin
        idle($urandom_range(3, 0));
      end
    end
    idle(1);
    while (part_q.size() != 0 || fin_q.size() != 0) begin
      @(negedge nvdla_core_clk);
    end
    $display("test %s: %0d items, %0d errors", name, N_ITEMS, errors - err0);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'hf9f1));
    errors          = 0;
    checks          = 0;
    test_name       = "reset";
    in_data         = '0;
    in_op           = '0;
    in_op_valid     = 1'b0;
    in_sel          = cacc_fp_pkg::SEL_PARTIAL;
    in_valid        = 1'b0;
    nvdla_core_rstn = 1'b0;
    repeat (2) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    run_test("partial_accumulation", 0);
    run_test("final_conversion", 1);
    run_test("operand_masking", 2);
    run_test("nan_propagation", 3);
    run_test("zero_result", 4);
    run_test("streaming", 5);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== cacc_fp_calc.f ====
+incdir+design
+incdir+tb
design/cacc_fp_pkg.sv
design/cacc_lead_sign_cnt.sv
design/cacc_fp_align.sv
design/cacc_fp_sum_nrml.sv
design/cacc_fp_round.sv
design/cacc_fp32_conv.sv
design/cacc_fp_calc.sv
tb/tb_cacc_fp_calc.sv

// ==== Makefile ====
# Verilator flow for the fp accumulation cell
VERILATOR ?= verilator
TOP       ?= tb_cacc_fp_calc
RTL_TOP   ?= cacc_fp_calc
FILELIST  ?= cacc_fp_calc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
